/* rtl/cic_comp_settings.svh */
`ifndef CIC_COMP_SETTINGS_SVH
`define CIC_COMP_SETTINGS_SVH

// I/Q sample width at input and output
`define CIC_SAMPLE_WIDTH 16

// Coefficient pairs, the filter length is 2*N+1
`define CIC_HALF_ORDER 16

// Signed coefficients in Q2.16
`define CIC_COEFF_WIDTH 18

// Headroom bits in the accumulator
`define CIC_GAIN_GUARD 20

// Fraction bits removed by rounding
`define CIC_DC_SHIFT 15

// Cycles from the tap-aligned last marker to output valid
// Covers pre-add, multiply, accumulate, centre add, round, saturate
`define CIC_OUT_LATENCY 6

`endif

/* rtl/cic_coeff_pkg.sv */
`include "cic_comp_settings.svh"

package cic_coeff_pkg;

    typedef logic signed [`CIC_COEFF_WIDTH-1:0] coeff_t;
    typedef logic [$clog2(`CIC_HALF_ORDER)-1:0] pair_index_t;

    // Pair k weights taps k and 2N-k
    localparam coeff_t COEFF_TABLE [0:`CIC_HALF_ORDER-1] = '{
        18'sb000000000010100011,
        18'sb111111110110001011,
        18'sb111111111100100001,
        18'sb000000100110001111,
        18'sb111111010111111100,
        18'sb111111001101101010,
        18'sb000010011001101100,
        18'sb111110111110010111,
        18'sb111100010001101010,
        18'sb000101110110110110,
        18'sb000000110101100011,
        18'sb110101000011010110,
        18'sb001000100100010111,
        18'sb001010011011110000,
        18'sb101010100011100100,
        18'sb111110000001110101
    };

    // Centre tap weight of 1.0 in Q2.16 is a plain shift
    localparam int CENTER_SHIFT = `CIC_COEFF_WIDTH - 2;

endpackage

/* rtl/cic_sample_pkg.sv */
`include "cic_comp_settings.svh"

package cic_sample_pkg;

    typedef logic signed [`CIC_SAMPLE_WIDTH-1:0] sample_t;

    // One extra bit for the symmetric pair sum
    typedef logic signed [`CIC_SAMPLE_WIDTH:0] preadd_t;

    typedef logic signed [`CIC_SAMPLE_WIDTH+`CIC_COEFF_WIDTH:0] product_t;

    typedef logic signed [`CIC_SAMPLE_WIDTH+`CIC_COEFF_WIDTH+`CIC_GAIN_GUARD:0] accum_t;

    // Rounded word keeps two sign bits above the shifted accumulator
    localparam int ROUNDED_WIDTH = $bits(accum_t) - `CIC_DC_SHIFT + 2;
    localparam int GUARD_WIDTH = ROUNDED_WIDTH - `CIC_SAMPLE_WIDTH;

    typedef struct packed {
        logic [GUARD_WIDTH-1:0] guard;
        sample_t                value;
    } rounded_fields_t;

    // Signed whole for direction, split fields for the range test
    typedef union packed {
        logic signed [ROUNDED_WIDTH-1:0] whole;
        rounded_fields_t                 fields;
    } rounded_u;

endpackage

/* rtl/cic_comp_sequencer.sv */
`timescale 1ns/1ns

`default_nettype none

`include "cic_comp_settings.svh"

module cic_comp_sequencer (
    input  wire logic                       i_clock,
    input  wire logic                       i_reset,
    input  wire logic                       i_valid,
    output      logic                       o_ready,
    output      logic                       o_shift,
    output      cic_coeff_pkg::pair_index_t o_pair_index,
    output      cic_coeff_pkg::coeff_t      o_coeff,
    output      logic                       o_first,
    output      logic                       o_last,
    output      logic                       o_valid
);
    import cic_coeff_pkg::*;

    pair_index_t                 pass_count;
    pair_index_t                 next_index;
    logic                        accept;
    logic                        last_aligned;
    logic [`CIC_OUT_LATENCY-1:0] valid_pipe;

    assign accept = i_valid && o_ready;
    assign o_shift = accept;
    assign next_index = accept ? '0 : o_pair_index + 1'b1;

    // Remaining pairs in the current pass
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pass_count <= '0;
            o_ready <= 1'b0;
            o_first <= 1'b0;
            o_last <= 1'b0;
        end else if (accept) begin
            pass_count <= pair_index_t'(`CIC_HALF_ORDER - 1);
            o_ready <= 1'b0;
            o_first <= 1'b1;
            o_last <= 1'b0;
        end else if (pass_count != '0) begin
            pass_count <= pass_count - 1'b1;
            o_ready <= (pass_count == pair_index_t'(1));
            o_first <= 1'b0;
            o_last <= (pass_count == pair_index_t'(1));
        end else begin
            o_ready <= 1'b1;
            o_first <= 1'b0;
            o_last <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (accept || pass_count != '0) begin
            o_pair_index <= next_index;
            o_coeff <= COEFF_TABLE[next_index];
        end
    end

    // Last marker lined up with the tap registers, then the data path depth
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            last_aligned <= 1'b0;
            valid_pipe <= '0;
        end else begin
            last_aligned <= o_last;
            valid_pipe <= {valid_pipe[`CIC_OUT_LATENCY-2:0], last_aligned};
        end
    end

    assign o_valid = valid_pipe[`CIC_OUT_LATENCY-1];

endmodule

`default_nettype wire

/* rtl/cic_comp_tap_line.sv */
`timescale 1ns/1ns

`default_nettype none

`include "cic_comp_settings.svh"

module cic_comp_tap_line (
    input  wire logic                       i_clock,
    input  wire logic                       i_reset,
    input  wire logic                       i_shift,
    input  wire cic_sample_pkg::sample_t    i_sample,
    input  wire cic_coeff_pkg::pair_index_t i_pair_index,
    output      cic_sample_pkg::sample_t    o_lhs,
    output      cic_sample_pkg::sample_t    o_rhs,
    output      cic_sample_pkg::sample_t    o_center
);
    import cic_sample_pkg::*;

    localparam int TAPS = 2 * `CIC_HALF_ORDER + 1;
    localparam int INDEX_WIDTH = $clog2(TAPS);

    sample_t                line [0:TAPS-1];
    logic [INDEX_WIDTH-1:0] rhs_index;

    // Mirror of the pair index about the centre tap
    assign rhs_index = INDEX_WIDTH'(TAPS - 1) - INDEX_WIDTH'(i_pair_index);

    // Newest sample at tap 0
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int k = 0; k < TAPS; k++) begin
                line[k] <= '0;
            end
        end else if (i_shift) begin
            line[0] <= i_sample;
            for (int k = 1; k < TAPS; k++) begin
                line[k] <= line[k-1];
            end
        end
    end

    always_ff @(posedge i_clock) begin
        o_lhs <= line[i_pair_index];
        o_rhs <= line[rhs_index];
        o_center <= line[`CIC_HALF_ORDER];
    end

endmodule

`default_nettype wire

/* rtl/cic_comp_mac.sv */
`timescale 1ns/1ns

`default_nettype none

module cic_comp_mac (
    input  wire logic                    i_clock,
    input  wire cic_sample_pkg::sample_t i_lhs,
    input  wire cic_sample_pkg::sample_t i_rhs,
    input  wire cic_sample_pkg::sample_t i_center,
    input  wire cic_coeff_pkg::coeff_t   i_coeff,
    input  wire logic                    i_first,
    input  wire logic                    i_last,
    output      cic_sample_pkg::accum_t  o_result
);
    import cic_sample_pkg::*;
    import cic_coeff_pkg::*;

    coeff_t     coeff_d1;
    coeff_t     coeff_d2;
    logic [2:0] first_d;
    logic [3:0] last_d;
    preadd_t    preadd;
    product_t   product;
    accum_t     accum;
    sample_t    center_hold;

    // Markers arrive with the pair index, taps one cycle later
    always_ff @(posedge i_clock) begin
        coeff_d1 <= i_coeff;
        coeff_d2 <= coeff_d1;
        first_d <= {first_d[1:0], i_first};
        last_d <= {last_d[2:0], i_last};
    end

    always_ff @(posedge i_clock) begin
        preadd <= preadd_t'(i_lhs) + preadd_t'(i_rhs);
        product <= preadd * coeff_d2;
        if (first_d[2]) begin
            accum <= accum_t'(product);
        end else begin
            accum <= accum + accum_t'(product);
        end
    end

    // Centre tap is still valid one cycle after the last pair
    always_ff @(posedge i_clock) begin
        if (last_d[0]) begin
            center_hold <= i_center;
        end
    end

    // Result stays put while the next pass accumulates
    always_ff @(posedge i_clock) begin
        if (last_d[3]) begin
            o_result <= accum + (accum_t'(center_hold) <<< CENTER_SHIFT);
        end
    end

endmodule

`default_nettype wire

/* rtl/cic_comp_round_sat.sv */
`timescale 1ns/1ns

`default_nettype none

`include "cic_comp_settings.svh"

module cic_comp_round_sat (
    input  wire logic                    i_clock,
    input  wire logic                    i_reset,
    input  wire cic_sample_pkg::accum_t  i_result,
    output      cic_sample_pkg::sample_t o_sample,
    output      logic                    o_pos_oflow,
    output      logic                    o_neg_oflow
);
    import cic_sample_pkg::*;

    localparam int ACC_WIDTH = $bits(accum_t);
    localparam int SMP_WIDTH = $bits(sample_t);
    localparam int RND_WIDTH = $bits(rounded_u);
    localparam logic [`CIC_DC_SHIFT-1:0] TIE_PATTERN = {1'b1, {(`CIC_DC_SHIFT-1){1'b0}}};
    localparam sample_t SAMPLE_MAX = {1'b0, {(SMP_WIDTH-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SMP_WIDTH-1){1'b0}}};

    logic signed [RND_WIDTH-1:0] truncated;
    logic                        round_up;
    rounded_u                    rounded;
    logic                        in_range;

    assign truncated = $signed(i_result[ACC_WIDTH-1:`CIC_DC_SHIFT]);

    // Half rounds up, an exact tie lands on the odd neighbour
    assign round_up = (i_result[`CIC_DC_SHIFT-1:0] == TIE_PATTERN) ?
                      ~i_result[`CIC_DC_SHIFT] : i_result[`CIC_DC_SHIFT-1];

    always_ff @(posedge i_clock) begin
        rounded.whole <= truncated + RND_WIDTH'(round_up);
    end

    // Fits when guard bits all copy the output sign
    assign in_range = (&{rounded.fields.guard, rounded.fields.value[SMP_WIDTH-1]}) ||
                      !(|{rounded.fields.guard, rounded.fields.value[SMP_WIDTH-1]});

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_sample <= '0;
            o_pos_oflow <= 1'b0;
            o_neg_oflow <= 1'b0;
        end else if (in_range) begin
            o_sample <= rounded.fields.value;
            o_pos_oflow <= 1'b0;
            o_neg_oflow <= 1'b0;
        end else if (rounded.whole < 0) begin
            o_sample <= SAMPLE_MIN;
            o_pos_oflow <= 1'b0;
            o_neg_oflow <= 1'b1;
        end else begin
            o_sample <= SAMPLE_MAX;
            o_pos_oflow <= 1'b1;
            o_neg_oflow <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/cic_comp_filter.sv */
`timescale 1ns/1ns

`default_nettype none

module cic_comp_filter (
    input  wire logic                    i_clock,
    input  wire logic                    i_reset,
    input  wire cic_sample_pkg::sample_t i_inph,
    input  wire cic_sample_pkg::sample_t i_quad,
    input  wire logic                    i_valid,
    output      logic                    o_ready,
    output      cic_sample_pkg::sample_t o_inph,
    output      cic_sample_pkg::sample_t o_quad,
    output      logic                    o_valid,
    output      logic                    o_inph_pos_oflow,
    output      logic                    o_inph_neg_oflow,
    output      logic                    o_quad_pos_oflow,
    output      logic                    o_quad_neg_oflow
);
    import cic_sample_pkg::*;
    import cic_coeff_pkg::*;

    logic        shift;
    pair_index_t pair_index;
    coeff_t      coeff;
    logic        first;
    logic        last;
    sample_t     inph_lhs, inph_rhs, inph_center;
    sample_t     quad_lhs, quad_rhs, quad_center;
    accum_t      inph_result;
    accum_t      quad_result;

    // One coefficient stream serves both channels
    cic_comp_sequencer u_sequencer (
        .i_clock(i_clock), .i_reset(i_reset), .i_valid(i_valid),
        .o_ready(o_ready), .o_shift(shift), .o_pair_index(pair_index),
        .o_coeff(coeff), .o_first(first), .o_last(last), .o_valid(o_valid)
    );

    cic_comp_tap_line u_inph_taps (
        .i_clock(i_clock), .i_reset(i_reset), .i_shift(shift), .i_sample(i_inph),
        .i_pair_index(pair_index), .o_lhs(inph_lhs), .o_rhs(inph_rhs),
        .o_center(inph_center)
    );

    cic_comp_tap_line u_quad_taps (
        .i_clock(i_clock), .i_reset(i_reset), .i_shift(shift), .i_sample(i_quad),
        .i_pair_index(pair_index), .o_lhs(quad_lhs), .o_rhs(quad_rhs),
        .o_center(quad_center)
    );

    cic_comp_mac u_inph_mac (
        .i_clock(i_clock), .i_lhs(inph_lhs), .i_rhs(inph_rhs), .i_center(inph_center),
        .i_coeff(coeff), .i_first(first), .i_last(last), .o_result(inph_result)
    );

    cic_comp_mac u_quad_mac (
        .i_clock(i_clock), .i_lhs(quad_lhs), .i_rhs(quad_rhs), .i_center(quad_center),
        .i_coeff(coeff), .i_first(first), .i_last(last), .o_result(quad_result)
    );

    cic_comp_round_sat u_inph_round (
        .i_clock(i_clock), .i_reset(i_reset), .i_result(inph_result),
        .o_sample(o_inph), .o_pos_oflow(o_inph_pos_oflow), .o_neg_oflow(o_inph_neg_oflow)
    );

    cic_comp_round_sat u_quad_round (
        .i_clock(i_clock), .i_reset(i_reset), .i_result(quad_result),
        .o_sample(o_quad), .o_pos_oflow(o_quad_pos_oflow), .o_neg_oflow(o_quad_neg_oflow)
    );

endmodule

`default_nettype wire

/* tb/cic_comp_filter_tb.sv */
`timescale 1ns/1ns

module cic_comp_filter_tb;
    import cic_coeff_pkg::*;
    import cic_sample_pkg::*;

    localparam int NUM_ROWS = 6;
    localparam int TAPS = 33;
    localparam int PAT_ZERO = 0;
    localparam int PAT_IMPULSE = 1;
    localparam int PAT_CONST = 2;
    localparam int PAT_ALT = 3;
    localparam int PAT_RANDOM = 4;
    localparam int PAT_TIE = 5;

    typedef int hist_t [TAPS];

    // Stimulus table with one row per test
    string test_name [NUM_ROWS] = '{"impulse", "random", "alternating",
                                    "const_pos", "const_neg", "tie"};
    int i_kind [NUM_ROWS] = '{PAT_IMPULSE, PAT_RANDOM, PAT_ALT, PAT_CONST, PAT_CONST, PAT_TIE};
    int q_kind [NUM_ROWS] = '{PAT_ZERO, PAT_RANDOM, PAT_ALT, PAT_CONST, PAT_CONST, PAT_TIE};
    int i_amp [NUM_ROWS] = '{8192, 0, 12000, 32767, -32768, 16384};
    int q_amp [NUM_ROWS] = '{0, 0, -9000, 32767, -32768, -16384};
    int count [NUM_ROWS] = '{34, 40, 36, 36, 36, 34};
    bit expect_sat [NUM_ROWS] = '{0, 0, 0, 1, 1, 0};

    logic    i_clock;
    logic    i_reset;
    sample_t i_inph;
    sample_t i_quad;
    logic    i_valid;
    logic    o_ready;
    sample_t o_inph;
    sample_t o_quad;
    logic    o_valid;
    logic    o_inph_pos_oflow;
    logic    o_inph_neg_oflow;
    logic    o_quad_pos_oflow;
    logic    o_quad_neg_oflow;

    int       seed = 59;
    int       cycle = 0;
    int       error_count = 0;
    int       test_errors = 0;
    int       check_count = 0;
    int       current_test = 0;
    hist_t    hist_i = '{default: 0};
    hist_t    hist_q = '{default: 0};
    int       exp_i [$];
    int       exp_q [$];
    bit [3:0] exp_flags [$];
    int       exp_cycle [$];
    int       last_i;
    int       last_q;
    bit [3:0] seen_flags;

    cic_comp_filter i_dut (
        .i_clock(i_clock), .i_reset(i_reset), .i_inph(i_inph), .i_quad(i_quad),
        .i_valid(i_valid), .o_ready(o_ready), .o_inph(o_inph), .o_quad(o_quad),
        .o_valid(o_valid), .o_inph_pos_oflow(o_inph_pos_oflow),
        .o_inph_neg_oflow(o_inph_neg_oflow), .o_quad_pos_oflow(o_quad_pos_oflow),
        .o_quad_neg_oflow(o_quad_neg_oflow)
    );

    initial begin
        i_clock = 1'b0;
        forever #10 i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(string what, int expected, int actual);
        check_count++;
        assert (expected == actual) else begin
            $display("FAILED %s: %s expected %0d actual %0d",
                     test_name[current_test], what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    function automatic int pattern_value(int kind, int amp, int n);
        int r;
        case (kind)
            PAT_IMPULSE: return (n == 0) ? amp : 0;
            PAT_CONST:   return amp;
            PAT_ALT:     return (n % 2 == 0) ? amp : -amp;
            PAT_RANDOM: begin
                r = $random(seed);
                return int'(sample_t'(r[15:0]));
            end
            // Zeros flush the history before one tie-producing sample
            PAT_TIE:     return (n < TAPS) ? 0 : amp;
            default:     return 0;
        endcase
    endfunction

    // Exact symmetric FIR sum with the newest sample at index 0
    function automatic longint fir_sum(hist_t h);
        longint sum;
        sum = longint'(h[16]) <<< CENTER_SHIFT;
        for (int k = 0; k < 16; k++) begin
            sum += longint'(COEFF_TABLE[k]) * longint'(h[k] + h[32-k]);
        end
        return sum;
    endfunction

    function automatic int round_sat(longint sum, output bit pos, output bit neg);
        longint q;
        longint rem;
        q = sum >>> 15;
        rem = sum & 64'h7fff;
        if (rem > 16384 || (rem == 16384 && q[0] == 1'b0)) begin
            q = q + 1;
        end
        pos = (q > 32767);
        neg = (q < -32768);
        if (pos) return 32767;
        if (neg) return -32768;
        return int'(q);
    endfunction

    task automatic model_step(int vi, int vq);
        bit pi;
        bit ni;
        bit pq;
        bit nq;
        int ri;
        int rq;
        for (int k = TAPS - 1; k > 0; k--) begin
            hist_i[k] = hist_i[k-1];
            hist_q[k] = hist_q[k-1];
        end
        hist_i[0] = vi;
        hist_q[0] = vq;
        ri = round_sat(fir_sum(hist_i), pi, ni);
        rq = round_sat(fir_sum(hist_q), pq, nq);
        exp_i.push_back(ri);
        exp_q.push_back(rq);
        exp_flags.push_back({pi, ni, pq, nq});
    endtask

    // Runs from a falling edge to the first falling edge with o_ready high again
    task automatic send_sample(int vi, int vq);
        int low_cycles;
        i_inph = sample_t'(vi);
        i_quad = sample_t'(vq);
        i_valid = 1'b1;
        while (!o_ready) @(negedge i_clock);
        @(posedge i_clock);
        model_step(vi, vq);
        @(negedge i_clock);
        exp_cycle.push_back(cycle);
        low_cycles = 0;
        while (!o_ready) begin
            low_cycles++;
            @(negedge i_clock);
        end
        check_value("ready low cycles", 15, low_cycles);
    endtask

    // Compare every result as o_valid pulses
    always @(negedge i_clock) begin
        if (o_valid) begin
            assert (exp_i.size() != 0) else begin
                $display("o_valid pulsed with no sample pending in test %s",
                         test_name[current_test]);
                error_count++;
                test_errors++;
            end
            if (exp_i.size() != 0) begin
                check_value("valid cycle", exp_cycle.pop_front() + 22, cycle);
                check_value("o_inph", exp_i.pop_front(), int'(o_inph));
                check_value("o_quad", exp_q.pop_front(), int'(o_quad));
                check_value("flags", int'(exp_flags.pop_front()),
                            int'({o_inph_pos_oflow, o_inph_neg_oflow,
                                  o_quad_pos_oflow, o_quad_neg_oflow}));
                last_i = int'(o_inph);
                last_q = int'(o_quad);
                seen_flags = seen_flags | {o_inph_pos_oflow, o_inph_neg_oflow,
                                           o_quad_pos_oflow, o_quad_neg_oflow};
            end
        end
    end

    initial begin
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += count[r];
        end
        repeat (40 * total + 100) @(posedge i_clock);
        $display("Timeout: the run did not finish in %0d cycles", 40 * total + 100);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_inph = '0;
        i_quad = '0;
        repeat (4) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        check_value("ready at release", 0, int'(o_ready));
        check_value("reset o_valid", 0, int'(o_valid));
        check_value("reset flags", 0, int'({o_inph_pos_oflow, o_inph_neg_oflow,
                                           o_quad_pos_oflow, o_quad_neg_oflow}));
        @(negedge i_clock);
        check_value("ready after reset", 1, int'(o_ready));

        for (int r = 0; r < NUM_ROWS; r++) begin
            current_test = r;
            test_errors = 0;
            seen_flags = '0;
            for (int n = 0; n < count[r]; n++) begin
                send_sample(pattern_value(i_kind[r], i_amp[r], n),
                            pattern_value(q_kind[r], q_amp[r], n));
            end
            i_valid = 1'b0;
            while (exp_i.size() != 0) @(negedge i_clock);
            // Constant rows reach a rail on both channels at some output
            if (expect_sat[r]) begin
                check_value("I saturated", 1, int'(seen_flags[3:2] != 2'b00));
                check_value("Q saturated", 1, int'(seen_flags[1:0] != 2'b00));
            end
            // Only tap 0 is set and 163 * 16384 sits exactly halfway
            if (i_kind[r] == PAT_TIE) begin
                check_value("I tie to odd", 81, last_i);
                check_value("Q tie to odd", -81, last_q);
            end
            $display("test %s: %0d samples, %0d errors", test_name[r], count[r], test_errors);
        end

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* cic_comp_filter.f */
+incdir+rtl
rtl/cic_coeff_pkg.sv
rtl/cic_sample_pkg.sv
rtl/cic_comp_sequencer.sv
rtl/cic_comp_tap_line.sv
rtl/cic_comp_mac.sv
rtl/cic_comp_round_sat.sv
rtl/cic_comp_filter.sv
tb/cic_comp_filter_tb.sv
